//--- rtl/fetch_pkg.sv
// fetch front end shared types: widths, opcode constant, instruction views, packets
`default_nettype none

package fetch_pkg;

	////////////////////////////////
	// widths and constants
	////////////////////////////////

	localparam int xlen = 32;                   // pc and data width

	localparam logic [6:0] opc_rtype = 7'b0110011; // register-register ops

	////////////////////////////////
	// instruction word, two layouts
	////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;                                 // r-type layout

	typedef struct packed {
		logic [11:0] imm;                       // signed 12-bit immediate
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} inst_i_t;                                 // i-type layout

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;                                   // same 32 bits read either way

	////////////////////////////////
	// packets
	////////////////////////////////

	typedef struct packed {
		logic [xlen-1:0] pc;                    // address of this inst
		logic [xlen-1:0] npc;                   // pc + 4
		inst_u           inst;
	} fetch_pkt_t;                              // 96 bits, fetch to decode

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [6:0]      opcode;
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;                   // zero unless r-type
		logic [2:0]      funct3;
		logic [xlen-1:0] imm;                   // zero for r-type
	} dec_pkt_t;                                // 89 bits, out of decode

endpackage

`default_nettype wire

//--- rtl/fetch_link_if.sv
// fetch to decode link: packet with valid one way, credit returns the other way
`timescale 1ns/10ps
`default_nettype none

interface fetch_link_if;

	logic                 valid;                // packet present this cycle
	fetch_pkg::fetch_pkt_t pkt;                 // pc, npc, inst
	logic                 credit;               // one pulse per freed buffer slot

	// fetch side
	modport sender (
		output valid,
		output pkt,
		input  credit
	);

	// decode side
	modport receiver (
		input  valid,
		input  pkt,
		output credit
	);

endinterface

`default_nettype wire

//--- rtl/inst_mem.sv
// instruction memory, 64-bit words, loadable write port and combinational read
`timescale 1ns/10ps
`default_nettype none

module inst_mem #(
	parameter int imem_words = 64                      // depth in 64-bit words
) (
	input  logic                          clock,
	input  logic                          load_en,     // write strobe from loader
	input  logic [$clog2(imem_words)-1:0] load_addr,   // word index
	input  logic [63:0]                   load_data,
	input  logic [$clog2(imem_words)-1:0] imem_addr,   // word index from fetch
	output logic [63:0]                   imem_data    // two instructions
);

	logic [63:0] mem [imem_words];                     // storage array

	////////////////////////////////
	// load port
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (load_en) begin
			mem[load_addr] <= load_data;               // one word per cycle
		end
	end

	////////////////////////////////
	// read port
	////////////////////////////////

	// data returns in the same cycle as the address
	assign imem_data = mem[imem_addr];

endmodule

`default_nettype wire

//--- rtl/if_stage.sv
// fetch stage with the pc register, instruction half select, credit counter and squash redirect
`timescale 1ns/10ps
`default_nettype none

module if_stage #(
	parameter int imem_words = 64,                     // memory depth in words
	parameter int buf_depth  = 4                       // decode buffer slots
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          squash,      // restart at redirect_pc
	input  logic                          stall,       // hold fetch
	input  logic [fetch_pkg::xlen-1:0]    redirect_pc,
	output logic [$clog2(imem_words)-1:0] imem_addr,   // 64-bit word index
	input  logic [63:0]                   imem_data,
	fetch_link_if.sender                  link
);

	localparam int aw = $clog2(imem_words);            // word index width
	localparam int cw = $clog2(buf_depth + 1);         // credit counter width

	logic [fetch_pkg::xlen-1:0] pc_reg;                // pc being fetched now
	logic [fetch_pkg::xlen-1:0] pc_plus_4;
	logic [cw-1:0]              credit_cnt;            // free slots in decode
	logic                       send;                  // packet leaves this cycle

	////////////////////////////////
	// memory address and half select
	////////////////////////////////

	assign imem_addr = pc_reg[aw+2:3];                 // drop byte and half bits
	assign pc_plus_4 = pc_reg + fetch_pkg::xlen'(4);

	// squash beats stall and nothing goes out in reset or without a credit
	assign send = !reset && !squash && !stall && (credit_cnt != '0);

	assign link.valid        = send;
	assign link.pkt.pc       = pc_reg;
	assign link.pkt.npc      = pc_plus_4;
	// bit 2 picks the upper or lower instruction of the word
	assign link.pkt.inst     = pc_reg[2] ? imem_data[63:32] : imem_data[31:0];

	////////////////////////////////
	// pc register
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= '0;                              // start at address 0
		end else if (squash) begin
			pc_reg <= redirect_pc;                     // new fetch stream
		end else if (send) begin
			pc_reg <= pc_plus_4;                       // sequential advance
		end
	end

	////////////////////////////////
	// credits toward decode
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			credit_cnt <= cw'(buf_depth);              // decode buffer empty
		end else if (squash) begin
			// buffer is flushed and pulses this cycle are dropped
			credit_cnt <= cw'(buf_depth);
		end else begin
			// spend and return may land in the same cycle
			credit_cnt <= credit_cnt - cw'(send) + cw'(link.credit);
		end
	end

endmodule

`default_nettype wire

//--- rtl/id_stage.sv
// decode stage: input buffer, field decode through the union, output credits
`timescale 1ns/10ps
`default_nettype none

module id_stage #(
	parameter int buf_depth   = 4,                     // input buffer slots
	parameter int out_credits = 2                      // credits toward consumer
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                squash,                // flush buffer and output
	fetch_link_if.receiver      link,
	input  logic                out_credit,            // consumer returns one credit
	output logic                dec_valid,             // one cycle per packet
	output fetch_pkg::dec_pkt_t dec_pkt
);

	localparam int pw = $clog2(buf_depth);             // pointer width
	localparam int nw = $clog2(buf_depth + 1);         // occupancy width
	localparam int ow = $clog2(out_credits + 1);       // out credit width

	fetch_pkg::fetch_pkt_t fifo_mem [buf_depth];       // packet storage
	logic [pw-1:0]         head;                       // next to pop
	logic [pw-1:0]         tail;                       // next to write
	logic [nw-1:0]         count;
	logic [ow-1:0]         out_cnt;                    // credits held for consumer
	logic                  pop;
	fetch_pkg::inst_u      word;                       // head instruction
	fetch_pkg::dec_pkt_t   dec_next;

	////////////////////////////////
	// input buffer
	////////////////////////////////

	// no pop during squash, stale entries must not reach the output
	assign pop         = !squash && (count != '0) && (out_cnt != '0);
	assign link.credit = pop;                          // slot freed, tell fetch

	always_ff @(posedge clock) begin
		if (link.valid) begin
			fifo_mem[tail] <= link.pkt;                // fetch credits guarantee room
		end
	end

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;                               // empty
		end else begin
			if (link.valid) begin
				tail <= (tail == pw'(buf_depth - 1)) ? '0 : tail + pw'(1);
			end
			if (pop) begin
				head <= (head == pw'(buf_depth - 1)) ? '0 : head + pw'(1);
			end
			count <= count + nw'(link.valid) - nw'(pop);
		end
	end

	////////////////////////////////
	// field decode
	////////////////////////////////

	assign word = fifo_mem[head].inst;

	always_comb begin
		dec_next.pc     = fifo_mem[head].pc;
		dec_next.opcode = word.r.opcode;
		dec_next.rd     = word.r.rd;
		dec_next.rs1    = word.r.rs1;
		dec_next.funct3 = word.i.funct3;
		if (word.r.opcode == fetch_pkg::opc_rtype) begin
			dec_next.rs2 = word.r.rs2;                 // register operand
			dec_next.imm = '0;
		end else begin
			dec_next.rs2 = '0;
			// sign extend the 12-bit field
			dec_next.imm = {{(fetch_pkg::xlen - 12){word.i.imm[11]}}, word.i.imm};
		end
	end

	////////////////////////////////
	// output register and credits
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= pop;                          // pulse per popped entry
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			dec_pkt <= dec_next;                       // payload, no reset
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out_cnt <= ow'(out_credits);
		end else begin
			// squash leaves these alone, the consumer owns them
			out_cnt <= out_cnt - ow'(pop) + ow'(out_credit);
		end
	end

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
// fetch front end top level: memory, fetch and decode with plain ports
`timescale 1ns/10ps
`default_nettype none

module fetch_top #(
	parameter int imem_words  = 64,
	parameter int buf_depth   = 4,
	parameter int out_credits = 2
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          squash,
	input  logic [fetch_pkg::xlen-1:0]    redirect_pc,
	input  logic                          stall,
	input  logic                          load_en,     // program loader
	input  logic [$clog2(imem_words)-1:0] load_addr,
	input  logic [63:0]                   load_data,
	output logic                          dec_valid,
	output logic [fetch_pkg::xlen-1:0]    dec_pc,
	output logic [6:0]                    dec_opcode,
	output logic [4:0]                    dec_rd,
	output logic [4:0]                    dec_rs1,
	output logic [4:0]                    dec_rs2,
	output logic [2:0]                    dec_funct3,
	output logic [fetch_pkg::xlen-1:0]    dec_imm,
	input  logic                          out_credit   // one pulse, one credit
);

	logic [$clog2(imem_words)-1:0] imem_addr;
	logic [63:0]                   imem_data;
	fetch_pkg::dec_pkt_t           dec_pkt;

	fetch_link_if link ();                             // fetch to decode

	inst_mem #(.imem_words(imem_words)) u_inst_mem (
		.clock, .load_en, .load_addr, .load_data, .imem_addr, .imem_data
	);

	if_stage #(.imem_words(imem_words), .buf_depth(buf_depth)) u_if_stage (
		.clock, .reset, .squash, .stall, .redirect_pc,
		.imem_addr, .imem_data, .link(link.sender)
	);

	id_stage #(.buf_depth(buf_depth), .out_credits(out_credits)) u_id_stage (
		.clock, .reset, .squash, .link(link.receiver),
		.out_credit, .dec_valid, .dec_pkt
	);

	// decoded packet onto plain ports
	assign dec_pc     = dec_pkt.pc;
	assign dec_opcode = dec_pkt.opcode;
	assign dec_rd     = dec_pkt.rd;
	assign dec_rs1    = dec_pkt.rs1;
	assign dec_rs2    = dec_pkt.rs2;
	assign dec_funct3 = dec_pkt.funct3;
	assign dec_imm    = dec_pkt.imm;

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
// testbench clock and reset source: 40 ns clock, reset held for five cycles on request
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
	parameter int period       = 40,               // ns
	parameter int reset_cycles = 5
) (
	input  logic reset_req,                        // rising edge starts a new reset
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// reset changes on the falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;                              // power-on reset
		forever begin
			repeat (reset_cycles) @(negedge clock);
			reset = 1'b0;
			@(posedge reset_req);
			reset = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- sim/fetch_checker.sv
// protocol checker for the fetch front end: output credits, link credits, reset
`timescale 1ns/10ps
`default_nettype none

module fetch_checker #(
	parameter int buf_depth   = 4,
	parameter int out_credits = 2
) (
	input logic                                 clock,
	input logic                                 reset,
	input logic                                 dec_valid,
	input logic [$clog2(out_credits + 1)-1:0]   out_cnt,      // decode credits held
	input logic [$clog2(buf_depth + 1)-1:0]     link_credit   // fetch credit counter
);

	localparam int cw = $clog2(buf_depth + 1);

	////////////////////////////////
	// credit rules
	////////////////////////////////

	// dec_valid follows a pop one cycle later, so the credit had to be there then
	a_out_credit: assert property (@(posedge clock) disable iff (reset)
		dec_valid |-> $past(out_cnt) != '0)
		else $error("dec_valid raised with no output credit held");

	// fetch never believes in more free slots than decode has
	a_link_credit: assert property (@(posedge clock) disable iff (reset)
		link_credit <= cw'(buf_depth))
		else $error("link credit count above buffer depth");

	////////////////////////////////
	// reset
	////////////////////////////////

	a_reset_quiet: assert property (@(posedge clock)
		$past(reset) |-> !dec_valid)
		else $error("dec_valid high during reset");

endmodule

`default_nettype wire

//--- sim/fetch_tb.sv
// testbench for the fetch front end: program load, table of tests, reference decode
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

	localparam int imem_words  = 64;
	localparam int buf_depth   = 4;
	localparam int out_credits = 2;
	localparam int aw          = $clog2(imem_words);
	localparam int n_tests     = 6;

	////////////////////////////////
	// test table, one column per field
	////////////////////////////////

	// kind 0 sequential, 1 mixed r/i; probabilities in percent
	// hold: cycles with out_credit low at start; squash 0 means none
	//                         t0       t1       t2       t3       t4        t5
	int          t_kind   [n_tests] = '{0,       1,       0,       0,       1,        0};
	int          t_stall  [n_tests] = '{0,       0,       0,       40,      20,       30};
	int          t_credit [n_tests] = '{100,     100,     100,     60,      70,       50};
	int          t_hold   [n_tests] = '{0,       0,       30,      0,       0,        0};
	int          t_squash [n_tests] = '{0,       0,       0,       0,       25,       40};
	logic [31:0] t_target [n_tests] = '{32'h0,   32'h0,   32'h0,   32'h0,   32'h104,  32'h1f8};
	int          t_npkt   [n_tests] = '{40,      60,      30,      50,      30,       20};

	logic        clock;
	logic        reset;
	logic        reset_req;
	logic        squash;
	logic [31:0] redirect_pc;
	logic        stall;
	logic        load_en;
	logic [aw-1:0] load_addr;
	logic [63:0] load_data;
	logic        out_credit;
	logic        dec_valid;
	logic [31:0] dec_pc;
	logic [6:0]  dec_opcode;
	logic [4:0]  dec_rd;
	logic [4:0]  dec_rs1;
	logic [4:0]  dec_rs2;
	logic [2:0]  dec_funct3;
	logic [31:0] dec_imm;

	int          seed = 32'h7059;
	logic [63:0] shadow [imem_words];            // copy of what was loaded
	logic [31:0] expected_pc;                    // next pc the consumer should see
	int          n_checks;
	int          n_errors;

	clock_gen #(.period(40), .reset_cycles(5)) u_clock_gen (
		.reset_req(reset_req), .clock(clock), .reset(reset)
	);

	fetch_top #(
		.imem_words(imem_words), .buf_depth(buf_depth), .out_credits(out_credits)
	) u_dut (
		.clock, .reset, .squash, .redirect_pc, .stall,
		.load_en, .load_addr, .load_data,
		.dec_valid, .dec_pc, .dec_opcode, .dec_rd, .dec_rs1, .dec_rs2,
		.dec_funct3, .dec_imm, .out_credit
	);

	bind fetch_top fetch_checker #(.buf_depth(buf_depth), .out_credits(out_credits)) u_checker (
		.clock(clock), .reset(reset), .dec_valid(dec_valid),
		.out_cnt(u_id_stage.out_cnt), .link_credit(u_if_stage.credit_cnt)
	);

	////////////////////////////////
	// helpers
	////////////////////////////////

	function automatic logic roll(input int pct);
		int r;
		r = $random(seed);
		r = r & 32'h7fffffff;                    // keep it positive
		return (r % 100) < pct;
	endfunction

	// instruction for slot idx (pc / 4)
	function automatic logic [31:0] make_inst(input int kind, input int idx);
		logic [31:0] ib;
		logic [31:0] r;
		ib = idx;
		r = $random(seed);
		if (kind == 0) begin
			return {ib[11:0], ib[4:0], 3'b000, ib[5:1], 7'b0010011};    // addi chain
		end
		if (r[0]) begin
			return {r[31:25], r[24:20], r[19:15], r[14:12], r[11:7], fetch_pkg::opc_rtype};
		end
		if (r[1]) begin
			return {r[31:20], r[19:15], r[14:12], r[11:7], 7'b0010011};
		end
		return {r[31:20], r[19:15], r[14:12], r[11:7], 7'b0000011};     // load form
	endfunction

	// word index wraps with the memory depth
	function automatic logic [31:0] inst_at(input logic [31:0] pc);
		logic [63:0] w;
		w = shadow[pc[aw+2:3]];
		if (pc[2]) begin
			return w[63:32];
		end
		return w[31:0];
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	// reference decode straight from the bit layout
	task automatic check_packet;
		logic [31:0] w;
		logic [6:0]  opc;
		logic [31:0] e_rs2;
		logic [31:0] e_imm;
		w   = inst_at(expected_pc);
		opc = w[6:0];
		if (opc == fetch_pkg::opc_rtype) begin
			e_rs2 = 32'(w[24:20]);
			e_imm = 32'h0;
		end else begin
			e_rs2 = 32'h0;
			e_imm = {{20{w[31]}}, w[31:20]};     // sign extended
		end
		check("dec_pc", dec_pc, expected_pc);
		check("dec_opcode", 32'(dec_opcode), 32'(opc));
		check("dec_rd", 32'(dec_rd), 32'(w[11:7]));
		check("dec_rs1", 32'(dec_rs1), 32'(w[19:15]));
		check("dec_rs2", 32'(dec_rs2), e_rs2);
		check("dec_funct3", 32'(dec_funct3), 32'(w[14:12]));
		check("dec_imm", dec_imm, e_imm);
	endtask

	task automatic load_program(input int kind);
		logic [63:0] word;
		for (int w = 0; w < imem_words; w++) begin
			@(negedge clock);
			word[31:0]  = make_inst(kind, 2 * w);
			word[63:32] = make_inst(kind, 2 * w + 1);
			shadow[w]   = word;
			load_en     = 1'b1;
			load_addr   = aw'(w);
			load_data   = word;
		end
		@(negedge clock);
		load_en = 1'b0;
	endtask

	task automatic apply_reset;
		@(negedge clock);
		reset_req = 1'b1;
		@(negedge clock);
		reset_req = 1'b0;
		wait (!reset);                           // released on a falling edge
	endtask

	////////////////////////////////
	// one table row
	////////////////////////////////

	task automatic run_test(input int t);
		int got;
		int owed;                                // credits the consumer still holds back
		int cycle;
		int hold_pulses;
		int errs_before;
		logic pending;                           // squash still to come
		got         = 0;
		owed        = 0;
		cycle       = 0;
		hold_pulses = 0;
		errs_before = n_errors;
		pending     = (t_squash[t] != 0);
		stall       = 1'b1;                      // keep fetch quiet while loading
		squash      = 1'b0;
		out_credit  = 1'b0;
		redirect_pc = t_target[t];
		load_program(t_kind[t]);
		apply_reset;
		expected_pc = 32'h0;
		while (pending || got < t_npkt[t]) begin
			@(negedge clock);
			// sample what the last rising edge produced
			if (dec_valid) begin
				check_packet;
				expected_pc = expected_pc + 32'd4;
				got++;
				owed++;
				if (cycle < t_hold[t]) begin
					hold_pulses++;
				end
			end
			// then drive the next cycle
			squash = pending && (cycle == t_squash[t]);
			if (squash) begin
				pending     = 1'b0;
				expected_pc = t_target[t];       // older packets must not show up
				got         = 0;
			end
			stall      = roll(t_stall[t]);
			out_credit = 1'b0;
			if (cycle >= t_hold[t] && owed > 0 && roll(t_credit[t])) begin
				out_credit = 1'b1;
				owed--;
			end
			cycle++;
		end
		@(negedge clock);
		squash     = 1'b0;
		out_credit = 1'b0;
		if (t_hold[t] != 0) begin
			check("hold_pulses", 32'(hold_pulses), 32'(out_credits));
		end
		$display("test %0d: %0d packets in %0d cycles, %0d errors",
			t, got, cycle, n_errors - errs_before);
	endtask

	////////////////////////////////
	// main sequence
	////////////////////////////////

	initial begin
		reset_req   = 1'b0;
		squash      = 1'b0;
		redirect_pc = 32'h0;
		stall       = 1'b1;
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = 64'h0;
		out_credit  = 1'b0;
		expected_pc = 32'h0;
		n_checks    = 0;
		n_errors    = 0;
		wait (!reset);
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// 20 cycles per expected packet plus load and reset time per test
	initial begin
		int limit;
		limit = 0;
		for (int t = 0; t < n_tests; t++) begin
			limit = limit + t_npkt[t] * 20 + t_hold[t] + imem_words + 100;
		end
		repeat (limit) @(posedge clock);
		$display("timeout: decoded packets stopped arriving within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
rtl/fetch_pkg.sv
rtl/fetch_link_if.sv
rtl/inst_mem.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/fetch_top.sv
sim/clock_gen.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim)
echo "$out"

# the run counts as passed only if the pass line was printed
echo "$out" | grep -q "Simulation completed successfully"
